//--- project.f
+incdir+test
src/bp_pkg.sv
src/bht.sv
src/bht_update_queue.sv
src/fetch_predict.sv
src/branch_predictor.sv
test/tb_branch_predictor.sv

//--- src/bht.sv
/*
  Direct-mapped branch history table.
  Each row covers one fetch block and holds one 2-bit saturating
  counter plus a valid bit per slot. The row addressed by vpc_i is
  read combinationally; a valid upd_i adjusts a single entry at the
  end of the cycle. A flush invalidates everything and leaves each
  counter at weakly taken.
*/
`timescale 1ns/1ps

module bht #(
  parameter int unsigned NR_ENTRIES = 64
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   flush_i,
  input  logic [bp_pkg::VLEN-1:0]                                vpc_i,
  input  bp_pkg::bht_update_t                                    upd_i,
  output bp_pkg::bht_prediction_t [bp_pkg::FETCH_WIDTH-1:0]      pred_o
);
  import bp_pkg::*;

  // table shape, one row per fetch block
  localparam int unsigned NR_ROWS  = NR_ENTRIES / FETCH_WIDTH;
  localparam int unsigned ROW_BITS = $clog2(NR_ROWS);
  // bit 0 of the pc is always zero, the slot field sits above it
  localparam int unsigned ROW_LSB  = SLOT_BITS + 1;
  localparam int unsigned ROW_MSB  = ROW_BITS + SLOT_BITS;

  // value written into every entry on flush
  localparam bht_entry_t FLUSH_ENTRY = '{valid: 1'b0, counter: 2'b10};

  bht_entry_t [FETCH_WIDTH-1:0] bht_q [NR_ROWS];

  logic [ROW_BITS-1:0]          rd_row;
  logic [ROW_BITS-1:0]          upd_row;
  logic [SLOT_BITS-1:0]         upd_slot;
  bht_entry_t [FETCH_WIDTH-1:0] rd_data;
  bht_entry_t                   upd_entry;

  // --------------------
  // counter rule
  // --------------------
  function automatic bht_entry_t count_update(bht_entry_t entry, logic taken);
    bht_entry_t result;
    result       = entry;
    result.valid = 1'b1;
    if (taken && (entry.counter != 2'b11)) begin
      result.counter = entry.counter + 2'd1;
    end else if (!taken && (entry.counter != 2'b00)) begin
      result.counter = entry.counter - 2'd1;
    end
    return result;
  endfunction

  // --------------------
  // lookup
  // --------------------
  assign rd_row  = vpc_i[ROW_MSB:ROW_LSB];
  assign rd_data = bht_q[rd_row];

  // predict taken in the upper half of the counter range
  for (genvar i = 0; i < FETCH_WIDTH; i++) begin : gen_pred
    assign pred_o[i].valid = rd_data[i].valid;
    assign pred_o[i].taken = rd_data[i].counter[1];
  end

  // --------------------
  // update
  // --------------------
  assign upd_row  = upd_i.pc[ROW_MSB:ROW_LSB];
  assign upd_slot = upd_i.pc[SLOT_BITS:1];

  always_comb begin
    upd_entry = count_update(bht_q[upd_row][upd_slot], upd_i.taken);
  end

  // flush wins over a pending update, which is then lost
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NR_ROWS; r++) begin
        bht_q[r] <= '0;
      end
    end else if (flush_i) begin
      for (int unsigned r = 0; r < NR_ROWS; r++) begin
        for (int unsigned s = 0; s < FETCH_WIDTH; s++) begin
          bht_q[r][s] <= FLUSH_ENTRY;
        end
      end
    end else if (upd_i.valid) begin
      bht_q[upd_row][upd_slot] <= upd_entry;
    end
  end

endmodule

//--- src/bht_update_queue.sv
/*
  Update queue between the branch resolver and the history table.
  Resolved branches are pushed on upd_i and the head is popped every
  cycle the queue is not empty. Each pop pulses upd_credit_o so the
  resolver can send again. Entries popped in debug mode reach the
  table with valid low and are therefore dropped.
*/
`timescale 1ns/1ps

module bht_update_queue #(
  parameter int unsigned UPD_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                debug_mode_i,
  input  bp_pkg::bht_update_t upd_i,
  output logic                upd_credit_o,
  output bp_pkg::bht_update_t upd_o
);
  import bp_pkg::*;

  localparam int unsigned PTR_BITS = (UPD_DEPTH > 1) ? $clog2(UPD_DEPTH) : 1;
  localparam int unsigned CNT_BITS = $clog2(UPD_DEPTH + 1);

  bht_update_t         mem_q [UPD_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic                push;
  logic                pop;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [PTR_BITS-1:0] ptr_next(logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(UPD_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // the resolver only sends while it holds a credit, so no full check
  assign push = upd_i.valid;
  assign pop  = (count_q != '0);

  // one credit per retired entry, also for dropped ones
  assign upd_credit_o = pop;

  always_comb begin
    upd_o       = mem_q[rd_ptr_q];
    upd_o.valid = pop && !debug_mode_i;
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= upd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- src/bp_pkg.sv
/*
  Shared definitions for the branch direction predictor.
  Holds the address width, the fetch block geometry and the packed
  structs passed between the fetch side, the update queue and the
  history table. Import it wherever one of these types is needed.
*/
package bp_pkg;

  // --------------------
  // geometry
  // --------------------
  // virtual address width
  localparam int unsigned VLEN = 32;
  // 16-bit slots per fetch block, compressed instructions assumed
  localparam int unsigned FETCH_WIDTH = 2;
  // width of a slot index inside one fetch block
  localparam int unsigned SLOT_BITS = $clog2(FETCH_WIDTH);

  // --------------------
  // structs
  // --------------------
  // one history table entry
  typedef struct packed {
    logic       valid;
    logic [1:0] counter;
  } bht_entry_t;

  // resolved branch coming back from execute
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] pc;
    logic            taken;
  } bht_update_t;

  // prediction for a single slot
  typedef struct packed {
    logic valid;
    logic taken;
  } bht_prediction_t;

  // lookup request from fetch
  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] vpc;
  } fetch_req_t;

  // registered prediction for a whole fetch block
  typedef struct packed {
    logic                                    valid;
    logic [VLEN-1:0]                         vpc;
    bht_prediction_t [FETCH_WIDTH-1:0]       pred;
    logic                                    taken_hit;
    logic [SLOT_BITS-1:0]                    taken_slot;
  } fetch_pred_t;

endpackage

//--- src/branch_predictor.sv
/*
  Top level of the branch direction predictor.
  Resolved branches enter through the update queue and are written
  into the history table; fetch lookups read the table and get a
  registered prediction one cycle after the request.
*/
`timescale 1ns/1ps

module branch_predictor #(
  parameter int unsigned NR_ENTRIES = 64,
  parameter int unsigned UPD_DEPTH  = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                debug_mode_i,
  input  bp_pkg::fetch_req_t  fetch_req_i,
  output bp_pkg::fetch_pred_t fetch_pred_o,
  input  bp_pkg::bht_update_t upd_i,
  output logic                upd_credit_o
);
  import bp_pkg::*;

  bht_update_t                       upd_q;
  bht_prediction_t [FETCH_WIDTH-1:0] row_pred;

  // --------------------
  // execute side
  // --------------------
  bht_update_queue #(
    .UPD_DEPTH(UPD_DEPTH)
  ) i_bht_update_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .debug_mode_i(debug_mode_i),
    .upd_i       (upd_i),
    .upd_credit_o(upd_credit_o),
    .upd_o       (upd_q)
  );

  bht #(
    .NR_ENTRIES(NR_ENTRIES)
  ) i_bht (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .vpc_i  (fetch_req_i.vpc),
    .upd_i  (upd_q),
    .pred_o (row_pred)
  );

  // --------------------
  // fetch side
  // --------------------
  fetch_predict i_fetch_predict (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_req_i (fetch_req_i),
    .row_pred_i  (row_pred),
    .fetch_pred_o(fetch_pred_o)
  );

endmodule

//--- src/fetch_predict.sv
/*
  Fetch-side prediction register.
  Captures the fetch request together with the table row read for it
  and presents both one cycle later. The first slot at or above the
  request's start slot that is valid and predicted taken is reported
  through taken_hit and taken_slot.
*/
`timescale 1ns/1ps

module fetch_predict (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  bp_pkg::fetch_req_t                                fetch_req_i,
  input  bp_pkg::bht_prediction_t [bp_pkg::FETCH_WIDTH-1:0] row_pred_i,
  output bp_pkg::fetch_pred_t                               fetch_pred_o
);
  import bp_pkg::*;

  logic                              valid_q;
  logic [VLEN-1:0]                   vpc_q;
  bht_prediction_t [FETCH_WIDTH-1:0] row_q;
  logic [SLOT_BITS-1:0]              start_slot;
  logic                              taken_hit;
  logic [SLOT_BITS-1:0]              taken_slot;

  // --------------------
  // request register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_req_i.valid) begin
      vpc_q <= fetch_req_i.vpc;
      row_q <= row_pred_i;
    end
  end

  // --------------------
  // first taken slot
  // --------------------
  // a block entered mid-row starts at the slot given by vpc bit 1
  assign start_slot = vpc_q[SLOT_BITS:1];

  // walk downwards so the lowest qualifying slot is kept last
  always_comb begin
    taken_hit  = 1'b0;
    taken_slot = '0;
    for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
      if ((i >= int'(start_slot)) && row_q[i].valid && row_q[i].taken) begin
        taken_hit  = 1'b1;
        taken_slot = SLOT_BITS'(i);
      end
    end
  end

  always_comb begin
    fetch_pred_o.valid      = valid_q;
    fetch_pred_o.vpc        = vpc_q;
    fetch_pred_o.pred       = row_q;
    fetch_pred_o.taken_hit  = taken_hit && valid_q;
    fetch_pred_o.taken_slot = taken_slot;
  end

endmodule

//--- test/tb_checks.svh
/*
  Checking helpers for the branch predictor testbench.
  Included inside the testbench module, so the tasks reach the clock,
  the DUT outputs and the credit counters directly.
*/
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// compare one observed value with its expected value
task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                           input string what);
  if (actual !== expected) begin
    abort_run($sformatf("Fail at %0t ns: %s, got %0h, expected %0h",
                        $time, what, actual, expected));
  end
endtask

// move on to the drive point of the next cycle
task automatic next_cycle();
  @(posedge clk_i);
  #10;
endtask

// wait until at most max_open sent updates still hold a credit
task automatic wait_credits(input int max_open);
  int cycles;
  cycles = 0;
  while (sent_count - credit_count > max_open) begin
    if (cycles == WAIT_LIMIT) begin
      abort_run("timed out waiting for update credits to return");
    end
    next_cycle();
    cycles++;
  end
endtask

`endif

//--- test/tb_branch_predictor.sv
/*
  Directed testbench for the branch direction predictor.
  A reference model of every counter follows the updates sent to the
  DUT and each lookup is compared with it slot by slot.
*/
`timescale 1ns/1ps

module tb_branch_predictor;
  import bp_pkg::*;

  localparam int unsigned NR_ENTRIES = 64;
  localparam int unsigned UPD_DEPTH  = 4;
  localparam int unsigned IDX_MSB    = $clog2(NR_ENTRIES);
  localparam int          WAIT_LIMIT = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        debug_mode_i;
  fetch_req_t  fetch_req_i;
  fetch_pred_t fetch_pred_o;
  bht_update_t upd_i;
  logic        upd_credit_o;

  // reference model indexed by pc bits above bit 0
  logic        model_valid [NR_ENTRIES];
  logic [1:0]  model_ctr [NR_ENTRIES];
  int          sent_count = 0;
  int          credit_count = 0;
  int          seed = 32'h3508_1aa0;
  fetch_pred_t last_pred;

  `include "tb_checks.svh"

  branch_predictor #(
    .NR_ENTRIES(NR_ENTRIES),
    .UPD_DEPTH (UPD_DEPTH)
  ) i_branch_predictor (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .debug_mode_i(debug_mode_i),
    .fetch_req_i (fetch_req_i),
    .fetch_pred_o(fetch_pred_o),
    .upd_i       (upd_i),
    .upd_credit_o(upd_credit_o)
  );

  always #50 clk_i = ~clk_i;

  // the credit pulse is stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && upd_credit_o) begin
      credit_count++;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic void fill_model(input logic [1:0] ctr);
    for (int i = 0; i < NR_ENTRIES; i++) begin
      model_valid[i] = 1'b0;
      model_ctr[i]   = ctr;
    end
  endfunction

  // --------------------
  // stimulus and lookup
  // --------------------
  // the model follows each update unless debug mode drops it
  task automatic send_update(input logic [VLEN-1:0] pc, input logic taken);
    int unsigned idx;
    wait_credits(UPD_DEPTH - 1);
    upd_i = '{valid: 1'b1, pc: pc, taken: taken};
    sent_count++;
    idx = pc[IDX_MSB:1];
    if (!debug_mode_i) begin
      model_valid[idx] = 1'b1;
      if (taken && model_ctr[idx] != 2'd3) begin
        model_ctr[idx]++;
      end else if (!taken && model_ctr[idx] != 2'd0) begin
        model_ctr[idx]--;
      end
    end
    next_cycle();
    upd_i.valid = 1'b0;
  endtask

  task automatic check_lookup(input logic [VLEN-1:0] vpc);
    int unsigned                       base;
    bht_prediction_t [FETCH_WIDTH-1:0] exp_pred;
    logic                              exp_hit;
    int                                exp_slot;
    base     = vpc[IDX_MSB:2] * FETCH_WIDTH;
    exp_hit  = 1'b0;
    exp_slot = 0;
    // the first valid taken slot at or above the start slot wins
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      exp_pred[s] = '{valid: model_valid[base + s], taken: model_ctr[base + s][1]};
      if (!exp_hit && s >= int'(vpc[1]) && exp_pred[s].valid && exp_pred[s].taken) begin
        exp_hit  = 1'b1;
        exp_slot = s;
      end
    end
    check_value(fetch_pred_o.valid, 1'b0, "prediction valid without a request");
    fetch_req_i = '{valid: 1'b1, vpc: vpc};
    next_cycle();
    last_pred         = fetch_pred_o;
    fetch_req_i.valid = 1'b0;
    check_value(last_pred.valid, 1'b1, "no prediction one cycle after the request");
    check_value(last_pred.vpc, vpc, $sformatf("vpc returned for %0h", vpc));
    check_value(last_pred.pred, exp_pred, $sformatf("slot predictions at %0h", vpc));
    check_value(last_pred.taken_hit, exp_hit, $sformatf("taken_hit at %0h", vpc));
    if (exp_hit) begin
      check_value(last_pred.taken_slot, exp_slot, $sformatf("taken_slot at %0h", vpc));
    end
    next_cycle();
  endtask

  task automatic check_all_rows();
    for (int r = 0; r < NR_ENTRIES / FETCH_WIDTH; r++) begin
      check_lookup(r * FETCH_WIDTH * 2);
    end
  endtask

  // --------------------
  // directed tests
  // --------------------
  // several blocks straight after reset with some entered at slot 1
  task automatic reset_state();
    check_value(upd_credit_o, 1'b0, "credit pulse after reset");
    for (int r = 0; r < 6; r++) begin
      check_lookup(32'h0000_4000 + r * 4 + (r % 2) * 2);
    end
  endtask

  // taken x4, not taken x5, taken x2 on one branch
  task automatic counter_saturation();
    logic [VLEN-1:0] pc;
    pc = 32'h8000_0046;
    for (int n = 0; n < 11; n++) begin
      send_update(pc, (n < 4) || (n > 8));
      wait_credits(0);
      check_lookup({pc[VLEN-1:2], 2'b00});
    end
  endtask

  // row 4 taken in both slots, row 9 only in slot 1, row 14 only in slot 0
  task automatic slot_selection();
    for (int r = 0; r < 3; r++) begin
      for (int n = 0; n < 2; n++) begin
        send_update(32'h10 + r * 20, r != 1);
        send_update(32'h12 + r * 20, r != 2);
      end
    end
    wait_credits(0);
    for (int r = 0; r < 6; r++) begin
      check_lookup(32'h10 + (r / 2) * 20 + (r % 2) * 2);
    end
    check_value(last_pred.pred[0].taken, 1'b1, "slot 0 of row 14 taken");
    check_value(last_pred.taken_hit, 1'b0, "slot below the start slot selected");
  endtask

  // a full queue back to back and then a random mix
  task automatic credit_flow();
    int          first;
    logic [31:0] pc_rnd;
    logic [31:0] taken_rnd;
    wait_credits(0);
    first = credit_count;
    for (int n = 0; n < UPD_DEPTH; n++) begin
      send_update(32'h0000_0100 + n * 2, n[0]);
    end
    wait_credits(0);
    for (int n = 0; n < 4; n++) begin
      next_cycle();
    end
    check_value(credit_count - first, UPD_DEPTH, "credit pulses for a full queue");
    for (int n = 0; n < 40; n++) begin
      pc_rnd    = $random(seed);
      taken_rnd = $random(seed);
      send_update(pc_rnd, taken_rnd[0]);
    end
    wait_credits(0);
    check_all_rows();
  endtask

  task automatic flush_check();
    wait_credits(0);
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    fill_model(2'b10);
    check_all_rows();
    // weakly taken after flush so one taken update saturates to 3
    send_update(32'h0000_0052, 1'b1);
    wait_credits(0);
    check_lookup(32'h0000_0050);
    check_value(last_pred.pred[1].valid, 1'b1, "slot valid after one update");
    check_value(last_pred.taken_hit, 1'b1, "taken after one update from flush");
    check_value(last_pred.taken_slot, 1'b1, "taken slot after flush");
  endtask

  task automatic debug_drop();
    int first;
    wait_credits(0);
    first        = credit_count;
    debug_mode_i = 1'b1;
    for (int n = 0; n < 3; n++) begin
      send_update(32'h0000_0052, 1'b0);
      send_update(32'h0000_0006, 1'b1);
    end
    wait_credits(0);
    debug_mode_i = 1'b0;
    check_value(credit_count - first, 6, "credits returned in debug mode");
    check_all_rows();
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    debug_mode_i = 1'b0;
    fetch_req_i  = '0;
    upd_i        = '0;
    fill_model(2'b00);
    // reset spans three rising edges
    for (int n = 0; n < 3; n++) begin
      @(posedge clk_i);
    end
    #10;
    rst_ni = 1'b1;
    reset_state();
    counter_saturation();
    slot_selection();
    credit_flow();
    flush_check();
    debug_drop();
    $display("Regression passed");
    $finish;
  end

endmodule
